// File: rtl/core_cfg_pkg.sv
// Processor-wide PC constants, imported by every block that holds or moves a PC
package core_cfg_pkg;

    // Program counter width
    localparam int unsigned PC_W = 32;

    // PC held by every thread after reset
    localparam logic [PC_W-1:0] START_PC = 32'h0000_0000;

    // One 32-bit instruction per issue slot
    localparam logic [PC_W-1:0] PC_STEP = 32'd4;

endpackage

// File: rtl/thread_pkg.sv
// Thread command encoding and thread id type, shared by the command path and the scheduler
package thread_pkg;

    // Upper bound set by the 3-bit thread id
    localparam int unsigned MAX_THREADS = 8;

    // Width of a thread id
    localparam int unsigned TRD_ID_W = $clog2(MAX_THREADS);

    // Thread id, wide enough for MAX_THREADS
    typedef logic [TRD_ID_W-1:0] trd_id_t;

    // Commands one thread can issue on another
    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,    // Idle cycle
        OP_INIT  = 3'd1,    // Start thread at init_pc, caller becomes parent
        OP_SLEEP = 3'd2,    // Stop issuing, keep PC
        OP_WAKE  = 3'd3,    // Resume a valid thread
        OP_KILL  = 3'd4     // Retire the thread
    } thread_op_t;

endpackage

// File: rtl/thread_cmd_if.sv
// Single-cycle thread command bundle from the top level into the CSR bank and each thread CSR
`timescale 1ns/1ns

interface thread_cmd_if
    import core_cfg_pkg::*, thread_pkg::*;
();

    thread_op_t      op;        // OP_NONE when idle
    trd_id_t         obj_trd;   // Target thread
    trd_id_t         act_trd;   // Issuing thread
    logic [PC_W-1:0] init_pc;   // Start PC, only for OP_INIT

    // Command source at the top level
    modport src (
        output op,
        output obj_trd,
        output act_trd,
        output init_pc
    );

    // Bank and per-thread CSR side
    modport dst (
        input op,
        input obj_trd,
        input act_trd,
        input init_pc
    );

endinterface

// File: rtl/thread_csr.sv
// Status and PC registers of one hardware thread, instantiated once per thread by the CSR bank
`timescale 1ns/1ns

module thread_csr
    import core_cfg_pkg::*, thread_pkg::*;
#(
    parameter int unsigned TRD_ID = 0
) (
    input  logic            clk,
    input  logic            rst_n,
    thread_cmd_if.dst       cmd,
    input  logic            pc_wr,     // Scheduler write to this thread
    input  logic [PC_W-1:0] nxt_pc,
    output logic [PC_W-1:0] cur_pc,
    output trd_id_t         par_trd,
    output logic            valid,
    output logic            running,
    output logic            error      // Illegal command on this thread
);

    localparam trd_id_t SELF = trd_id_t'(TRD_ID);

    logic hit;          // Command addresses this thread
    logic allowed;      // Caller is parent or self
    logic is_init;
    logic is_slp_kill;

    assign hit         = (cmd.obj_trd == SELF);
    assign allowed     = (cmd.act_trd == par_trd) || (cmd.act_trd == SELF);
    assign is_init     = hit && (cmd.op == OP_INIT);
    assign is_slp_kill = hit && ((cmd.op == OP_SLEEP) || (cmd.op == OP_KILL));

    // Status, priority init > sleep > wake > kill
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid   <= 1'b0;
            running <= 1'b0;
            par_trd <= '0;
        end else if (is_init) begin
            valid   <= 1'b1;
            running <= 1'b1;
            par_trd <= cmd.act_trd;             // Caller owns the new thread
        end else if (hit && (cmd.op == OP_SLEEP) && allowed) begin
            running <= 1'b0;
        end else if (hit && (cmd.op == OP_WAKE) && valid) begin
            running <= 1'b1;                    // No ownership check on wake
        end else if (hit && (cmd.op == OP_KILL) && valid && allowed) begin
            valid   <= 1'b0;
            running <= 1'b0;
        end
    end

    // PC, init beats a scheduler write in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_pc <= START_PC;
        end else if (is_init) begin
            cur_pc <= cmd.init_pc;
        end else if (pc_wr) begin
            cur_pc <= nxt_pc;
        end
    end

    // Same-cycle error, init of a live thread is still applied
    always_comb begin
        error = 1'b0;
        if (is_slp_kill && !allowed) begin
            error = 1'b1;                       // Foreign sleep or kill
        end
        if (is_init && valid) begin
            error = 1'b1;                       // Re-init
        end
    end

    // A thread can only run while it exists
    a_running_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        running |-> valid
    ) else $error("thread %0d running while not valid", TRD_ID);

endmodule

// File: rtl/thread_csr_bank.sv
// Bank of per-thread CSRs with PC write steering, status gathering and command error merge
`timescale 1ns/1ns

module thread_csr_bank
    import core_cfg_pkg::*, thread_pkg::*;
#(
    parameter int unsigned NUM_THREADS = 8
) (
    input  logic                              clk,
    input  logic                              rst_n,
    thread_cmd_if.dst                         cmd,
    input  logic                              pc_wr,
    input  trd_id_t                           pc_wr_trd,
    input  logic [PC_W-1:0]                   nxt_pc,
    output logic [NUM_THREADS-1:0]            valid_vec,
    output logic [NUM_THREADS-1:0]            running_vec,
    output logic [NUM_THREADS-1:0][PC_W-1:0]  cur_pc_vec,
    output logic                              cmd_error
);

    logic [NUM_THREADS-1:0] wr_en;      // One-hot PC write
    logic [NUM_THREADS-1:0] err_vec;    // Per-thread command errors

    for (genvar i = 0; i < NUM_THREADS; i++) begin : g_trd
        assign wr_en[i] = pc_wr && (pc_wr_trd == trd_id_t'(i));

        thread_csr #(
            .TRD_ID (i)
        ) u_csr (
            .clk     (clk),
            .rst_n   (rst_n),
            .cmd     (cmd),
            .pc_wr   (wr_en[i]),
            .nxt_pc  (nxt_pc),
            .cur_pc  (cur_pc_vec[i]),
            .par_trd (),                // Parent only matters inside the CSR
            .valid   (valid_vec[i]),
            .running (running_vec[i]),
            .error   (err_vec[i])
        );
    end

    // Targets beyond NUM_THREADS match no CSR, so they stay silent
    assign cmd_error = |err_vec;

    // Scheduler writes always land on exactly one existing thread
    a_wr_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(wr_en) && (!pc_wr || $onehot(wr_en))
    ) else $error("PC write enable 0x%0h for thread 0x%0h", wr_en, pc_wr_trd);

endmodule

// File: rtl/thread_sched.sv
// Round-robin issue scheduler that presents one running thread's PC per cycle and advances it
`timescale 1ns/1ns

module thread_sched
    import core_cfg_pkg::*, thread_pkg::*;
#(
    parameter int unsigned NUM_THREADS = 8
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [NUM_THREADS-1:0]            running_vec,
    input  logic [NUM_THREADS-1:0][PC_W-1:0]  cur_pc_vec,
    input  logic                              redirect,     // Replace PC of issue_trd
    input  logic [PC_W-1:0]                   redirect_pc,
    output logic                              pc_wr,
    output trd_id_t                           pc_wr_trd,
    output logic [PC_W-1:0]                   nxt_pc,
    output logic                              issue_valid,
    output trd_id_t                           issue_trd,
    output logic [PC_W-1:0]                   issue_pc
);

    if ((NUM_THREADS < 2) || (NUM_THREADS > MAX_THREADS)) begin : g_cfg_check
        $error("NUM_THREADS %0d outside 2..%0d", NUM_THREADS, MAX_THREADS);
    end

    trd_id_t         last_trd;      // Most recently issued thread
    logic            redir_take;    // Redirect of the thread now on issue
    logic            found;
    trd_id_t         pick;
    logic [PC_W-1:0] sel_pc;

    assign redir_take = redirect && issue_valid;

    // Lowest running thread above last_trd with wrap-around
    always_comb begin
        int idx;
        found  = 1'b0;
        pick   = '0;
        sel_pc = '0;
        for (int off = 1; off <= NUM_THREADS; off++) begin
            idx = int'(last_trd) + off;
            if (idx >= NUM_THREADS) begin
                idx = idx - NUM_THREADS;
            end
            if (!found && running_vec[idx]) begin
                found  = 1'b1;
                pick   = trd_id_t'(idx);
                sel_pc = cur_pc_vec[idx];
            end
        end
    end

    // Redirect steals the slot from the advance write
    always_comb begin
        if (redir_take) begin
            pc_wr     = 1'b1;
            pc_wr_trd = issue_trd;
            nxt_pc    = redirect_pc;
        end else begin
            pc_wr     = found;
            pc_wr_trd = pick;
            nxt_pc    = sel_pc + PC_STEP;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_valid <= 1'b0;
            issue_trd   <= '0;
            last_trd    <= trd_id_t'(NUM_THREADS - 1);  // Thread 0 goes first
        end else if (redir_take) begin
            issue_valid <= 1'b0;                        // Bubble for the redirect
        end else begin
            issue_valid <= found;
            if (found) begin
                issue_trd <= pick;
                last_trd  <= pick;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!redir_take && found) begin
            issue_pc <= sel_pc;
        end
    end

    // Redirect rewrites the thread that the round robin issued last
    a_redirect_slot: assert property (
        @(posedge clk) disable iff (!rst_n)
        redir_take |-> pc_wr && (pc_wr_trd == last_trd)
    ) else $error("redirect write to thread 0x%0h, last issued 0x%0h", pc_wr_trd, last_trd);

endmodule

// File: rtl/thread_ctrl_top.sv
// Thread control block top level, instantiated by the processor front end or the testbench
`timescale 1ns/1ns

module thread_ctrl_top
    import core_cfg_pkg::*, thread_pkg::*;
#(
    parameter int unsigned NUM_THREADS = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  thread_op_t             cmd_op,
    input  trd_id_t                cmd_obj_trd,
    input  trd_id_t                cmd_act_trd,
    input  logic [PC_W-1:0]        cmd_init_pc,
    input  logic                   redirect,
    input  logic [PC_W-1:0]        redirect_pc,
    output logic                   issue_valid,
    output trd_id_t                issue_trd,
    output logic [PC_W-1:0]        issue_pc,
    output logic [NUM_THREADS-1:0] thread_valid,
    output logic [NUM_THREADS-1:0] thread_running,
    output logic                   cmd_error
);

    logic                             pc_wr;
    trd_id_t                          pc_wr_trd;
    logic [PC_W-1:0]                  nxt_pc;
    logic [NUM_THREADS-1:0][PC_W-1:0] cur_pc_vec;

    thread_cmd_if u_cmd_if ();

    // Command pins onto the bundle
    assign u_cmd_if.op      = cmd_op;
    assign u_cmd_if.obj_trd = cmd_obj_trd;
    assign u_cmd_if.act_trd = cmd_act_trd;
    assign u_cmd_if.init_pc = cmd_init_pc;

    thread_csr_bank #(
        .NUM_THREADS (NUM_THREADS)
    ) u_bank (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd         (u_cmd_if),
        .pc_wr       (pc_wr),
        .pc_wr_trd   (pc_wr_trd),
        .nxt_pc      (nxt_pc),
        .valid_vec   (thread_valid),
        .running_vec (thread_running),
        .cur_pc_vec  (cur_pc_vec),
        .cmd_error   (cmd_error)
    );

    thread_sched #(
        .NUM_THREADS (NUM_THREADS)
    ) u_sched (
        .clk         (clk),
        .rst_n       (rst_n),
        .running_vec (thread_running),
        .cur_pc_vec  (cur_pc_vec),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc_wr       (pc_wr),
        .pc_wr_trd   (pc_wr_trd),
        .nxt_pc      (nxt_pc),
        .issue_valid (issue_valid),
        .issue_trd   (issue_trd),
        .issue_pc    (issue_pc)
    );

endmodule

// File: testbench/tb_clk_gen.sv
// Testbench clock and reset source, instantiated once by the thread control testbench
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;                  // Released on an edge, seen at the next one
    end

endmodule

// File: testbench/thread_ctrl_tb.sv
// Testbench for the thread control block, checks status, issue order and PCs against a model
`timescale 1ns/1ns

module thread_ctrl_tb
    import core_cfg_pkg::*, thread_pkg::*;
();

    localparam int          NUM_THREADS = 4;
    localparam int          N_STEPS     = 7;        // Directed stages plus random phase
    localparam int          RAND_CYCLES = 80;
    localparam int          LIMIT       = N_STEPS * 40 + 200;
    localparam int unsigned RAND_SEED   = 32'h744b_b4a4;

    logic                   clk;
    logic                   rst_n;
    thread_op_t             cmd_op;
    trd_id_t                cmd_obj_trd;
    trd_id_t                cmd_act_trd;
    logic [PC_W-1:0]        cmd_init_pc;
    logic                   redirect;
    logic [PC_W-1:0]        redirect_pc;
    logic                   issue_valid;
    trd_id_t                issue_trd;
    logic [PC_W-1:0]        issue_pc;
    logic [NUM_THREADS-1:0] thread_valid;
    logic [NUM_THREADS-1:0] thread_running;
    logic                   cmd_error;

    // Model state, sized for every id a command can name
    logic [MAX_THREADS-1:0] m_valid;
    logic [MAX_THREADS-1:0] m_running;
    trd_id_t                m_par [MAX_THREADS];
    logic [PC_W-1:0]        m_pc [MAX_THREADS];
    trd_id_t                m_last;
    logic                   m_iv;               // Expected issue_valid
    trd_id_t                m_it;
    logic [PC_W-1:0]        m_ipc;
    logic                   exp_error;
    logic [MAX_THREADS-1:0] prev_running;       // Running set one edge back
    logic                   issued_was_running;
    int                     err_count = 0;

    tb_clk_gen #(
        .PERIOD_NS  (20),
        .RST_CYCLES (10)
    ) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    thread_ctrl_top #(
        .NUM_THREADS (NUM_THREADS)
    ) u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd_op         (cmd_op),
        .cmd_obj_trd    (cmd_obj_trd),
        .cmd_act_trd    (cmd_act_trd),
        .cmd_init_pc    (cmd_init_pc),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .issue_valid    (issue_valid),
        .issue_trd      (issue_trd),
        .issue_pc       (issue_pc),
        .thread_valid   (thread_valid),
        .thread_running (thread_running),
        .cmd_error      (cmd_error)
    );

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        err_count++;
        $display("error %s 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    endtask

    task automatic report_failure(input string what);
        err_count++;
        $display("check failed: %s at %0t", what, $time);
    endtask

    function automatic logic [PC_W-1:0] random_pc();
        return $urandom & 32'hFFFF_FFFC;            // Word aligned
    endfunction

    // Reference model, one step per edge
    always @(posedge clk or negedge rst_n) begin : model_step
        logic [MAX_THREADS-1:0] nv;
        logic [MAX_THREADS-1:0] nr;
        trd_id_t                np [MAX_THREADS];
        logic [PC_W-1:0]        npc [MAX_THREADS];
        trd_id_t                tgt;
        trd_id_t                cand;
        logic                   found;
        logic                   ok;
        if (!rst_n) begin
            m_valid   <= '0;
            m_running <= '0;
            m_last    <= trd_id_t'(NUM_THREADS - 1);
            m_iv      <= 1'b0;
            m_it      <= '0;
            m_ipc     <= '0;
            for (int i = 0; i < MAX_THREADS; i++) begin
                m_par[i] <= '0;
                m_pc[i]  <= START_PC;
            end
        end else begin
            nv    = m_valid;
            nr    = m_running;
            np    = m_par;
            npc   = m_pc;
            found = 1'b0;
            cand  = '0;
            // Scheduler slot first, a same-edge init overrides its PC write
            if (redirect && m_iv) begin
                npc[m_it] = redirect_pc;
                m_iv      <= 1'b0;
            end else begin
                for (int off = 1; off <= NUM_THREADS; off++) begin
                    tgt = trd_id_t'((int'(m_last) + off) % NUM_THREADS);
                    if (!found && m_running[tgt]) begin
                        found = 1'b1;
                        cand  = tgt;
                    end
                end
                m_iv <= found;
                if (found) begin
                    m_it      <= cand;
                    m_ipc     <= m_pc[cand];
                    m_last    <= cand;
                    npc[cand] = m_pc[cand] + PC_STEP;
                end
            end
            tgt = cmd_obj_trd;
            ok  = (cmd_act_trd == m_par[tgt]) || (cmd_act_trd == tgt);
            if (int'(tgt) < NUM_THREADS) begin
                case (cmd_op)
                    OP_INIT: begin
                        nv[tgt]  = 1'b1;
                        nr[tgt]  = 1'b1;
                        np[tgt]  = cmd_act_trd;
                        npc[tgt] = cmd_init_pc;
                    end
                    OP_SLEEP: begin
                        if (ok) nr[tgt] = 1'b0;
                    end
                    OP_WAKE: begin
                        if (m_valid[tgt]) nr[tgt] = 1'b1;
                    end
                    OP_KILL: begin
                        if (m_valid[tgt] && ok) begin
                            nv[tgt] = 1'b0;
                            nr[tgt] = 1'b0;
                        end
                    end
                    default: begin
                    end
                endcase
            end
            m_valid   <= nv;
            m_running <= nr;
            m_par     <= np;
            m_pc      <= npc;
        end
    end

    // Foreign sleep or kill, or init of a live thread
    always_comb begin
        exp_error = 1'b0;
        if (int'(cmd_obj_trd) < NUM_THREADS) begin
            if (((cmd_op == OP_SLEEP) || (cmd_op == OP_KILL)) &&
                (cmd_act_trd != m_par[cmd_obj_trd]) && (cmd_act_trd != cmd_obj_trd)) begin
                exp_error = 1'b1;
            end
            if ((cmd_op == OP_INIT) && m_valid[cmd_obj_trd]) begin
                exp_error = 1'b1;
            end
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_running <= '0;
        end else begin
            prev_running <= {{(MAX_THREADS - NUM_THREADS){1'b0}}, thread_running};
        end
    end

    assign issued_was_running = prev_running[issue_trd];

    a_valid: assert property (@(posedge clk) disable iff (!rst_n)
        thread_valid == m_valid[NUM_THREADS-1:0])
        else report_mismatch("thread_valid", 32'($sampled(thread_valid)), 32'($sampled(m_valid)));

    a_running: assert property (@(posedge clk) disable iff (!rst_n)
        thread_running == m_running[NUM_THREADS-1:0])
        else report_mismatch("thread_running", 32'($sampled(thread_running)),
                             32'($sampled(m_running)));

    a_issue_valid: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid == m_iv)
        else report_mismatch("issue_valid", 32'($sampled(issue_valid)), 32'($sampled(m_iv)));

    a_issue_trd: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> (issue_trd == m_it))
        else report_mismatch("issue_trd", 32'($sampled(issue_trd)), 32'($sampled(m_it)));

    a_issue_pc: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> (issue_pc == m_ipc))
        else report_mismatch("issue_pc", $sampled(issue_pc), $sampled(m_ipc));

    a_cmd_error: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_error == exp_error)
        else report_mismatch("cmd_error", 32'($sampled(cmd_error)), 32'($sampled(exp_error)));

    a_issued_running: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> issued_was_running)
        else report_failure("a thread was issued that was not running");

    a_redirect_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        (redirect && issue_valid) |=> !issue_valid)
        else report_failure("issue_valid stayed high in the cycle after a redirect");

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clk);
    endtask

    task automatic send_cmd(input thread_op_t op, input int obj, input int act,
                            input logic [PC_W-1:0] pc);
        @(posedge clk);
        cmd_op      <= op;
        cmd_obj_trd <= trd_id_t'(obj);
        cmd_act_trd <= trd_id_t'(act);
        cmd_init_pc <= pc;
        @(posedge clk);
        cmd_op      <= OP_NONE;
    endtask

    task automatic pulse_redirect(input logic [PC_W-1:0] pc);
        @(posedge clk);
        redirect    <= 1'b1;
        redirect_pc <= pc;
        @(posedge clk);
        redirect    <= 1'b0;
    endtask

    task automatic random_traffic(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            cmd_op      <= thread_op_t'($urandom_range(0, 4));
            cmd_obj_trd <= trd_id_t'($urandom_range(0, NUM_THREADS));  // Top id has no CSR
            cmd_act_trd <= trd_id_t'($urandom_range(0, NUM_THREADS - 1));
            cmd_init_pc <= random_pc();
            redirect    <= ($urandom_range(0, 3) == 0);
            redirect_pc <= random_pc();
        end
        @(posedge clk);
        cmd_op   <= OP_NONE;
        redirect <= 1'b0;
    endtask

    initial begin : stimulus
        cmd_op      = OP_NONE;
        cmd_obj_trd = '0;
        cmd_act_trd = '0;
        cmd_init_pc = '0;
        redirect    = 1'b0;
        redirect_pc = '0;
        void'($urandom(RAND_SEED));
        wait (rst_n);
        idle(3);
        send_cmd(OP_INIT, 0, 0, random_pc());         // Lone thread
        idle(6);
        send_cmd(OP_INIT, 2, 0, random_pc());
        send_cmd(OP_INIT, 1, 0, random_pc());
        idle(8);
        send_cmd(OP_SLEEP, 2, 3, '0);                 // Foreign, rejected
        send_cmd(OP_SLEEP, 2, 0, '0);                 // Parent
        send_cmd(OP_KILL, 1, 1, '0);                  // Self
        send_cmd(OP_KILL, 0, 3, '0);                  // Foreign, rejected
        send_cmd(OP_INIT, 0, 1, random_pc());         // Live thread
        idle(4);
        send_cmd(OP_WAKE, 2, 3, '0);                  // Sleeping thread resumes
        send_cmd(OP_WAKE, 1, 3, '0);                  // Killed thread stays down
        send_cmd(OP_WAKE, 3, 0, '0);                  // Never started
        idle(6);
        repeat (3) begin
            pulse_redirect(random_pc());
            idle($urandom_range(1, 4));
        end
        random_traffic(RAND_CYCLES);
        idle(5);
        $display("run complete, %0d errors counted", err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (LIMIT) @(posedge clk);
        $display("timeout: the test sequence did not finish within %0d cycles", LIMIT);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: src.f
rtl/core_cfg_pkg.sv
rtl/thread_pkg.sv
rtl/thread_cmd_if.sv
rtl/thread_csr.sv
rtl/thread_csr_bank.sv
rtl/thread_sched.sv
rtl/thread_ctrl_top.sv
testbench/tb_clk_gen.sv
testbench/thread_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the thread control testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f src.f \
    --top-module thread_ctrl_tb \
    -Mdir obj_dir

./obj_dir/Vthread_ctrl_tb | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
